// ==== crc_bus_pkg.sv ====
`default_nettype none

// Bus side of the CRC slave
// Word types, register map and AHB-Lite encodings
package crc_bus_pkg;

	// HADDR, HWDATA, HRDATA and every 32-bit register
	typedef logic [31:0] bus_word_t;

	// Word index taken from HADDR[4:2]
	typedef logic [2:0] reg_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	localparam reg_addr_t REG_DR   = 3'd0;
	localparam reg_addr_t REG_IDR  = 3'd1;
	localparam reg_addr_t REG_CR   = 3'd2;
	localparam reg_addr_t REG_INIT = 3'd4;
	localparam reg_addr_t REG_POL  = 3'd5;

	// Transfer type codes on HTRANS
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// The slave never signals an error
	localparam logic RESP_OKAY = 1'b0;

	// Control register contents after reset
	localparam logic [4:0] CR_RESET = 5'h00;

endpackage

`default_nettype wire

// ==== crc_calc_pkg.sv ====
`default_nettype none

// CRC side of the accelerator
// Value types, size and reversal codes, engine states
package crc_calc_pkg;

	// CRC, polynomial and initial value
	typedef logic [31:0] crc_word_t;

	// Scratch register
	typedef logic [7:0] idr_t;

	// Polynomial width select
	typedef logic [1:0] poly_size_t;
	localparam poly_size_t POLY_32 = 2'b00;
	localparam poly_size_t POLY_16 = 2'b01;
	localparam poly_size_t POLY_8  = 2'b10;
	localparam poly_size_t POLY_7  = 2'b11;

	// Input bit reversal select
	typedef logic [1:0] rev_in_t;
	localparam rev_in_t REV_NONE = 2'b00;
	localparam rev_in_t REV_BYTE = 2'b01;
	localparam rev_in_t REV_HALF = 2'b10;
	localparam rev_in_t REV_WORD = 2'b11;

	// HSIZE code stored with each data word
	typedef logic [1:0] bus_size_t;
	localparam bus_size_t SIZE_BYTE = 2'b00;
	localparam bus_size_t SIZE_HALF = 2'b01;
	localparam bus_size_t SIZE_WORD = 2'b10;

	// Programmable register reset values
	localparam crc_word_t INIT_RESET = 32'hFFFF_FFFF;
	localparam crc_word_t POLY_RESET = 32'h04C1_1DB7;

	typedef enum logic [1:0] {ENG_IDLE, ENG_LOAD, ENG_SHIFT} engine_state_t;

endpackage

`default_nettype wire

// ==== host_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_interface
	import crc_bus_pkg::*, crc_calc_pkg::*;
(
	input  wire             HCLK,
	input  wire             HRESETn,
	input  wire             HSElx,
	input  wire bus_word_t  HADDR,
	input  wire [1:0]       HTRANS,
	input  wire [2:0]       HSIZE,
	input  wire             HWRITE,
	input  wire bus_word_t  HWDATA,
	input  wire             HREADY,
	input  wire crc_word_t  crc_out,
	input  wire crc_word_t  crc_init_out,
	input  wire crc_word_t  crc_poly_out,
	input  wire idr_t       crc_idr_out,
	input  wire             buffer_full,
	input  wire             reset_pending,
	input  wire             read_wait,
	output bus_word_t       HRDATA,
	output logic            HREADYOUT,
	output logic            HRESP,
	output bus_word_t       bus_wr,
	output bus_size_t       bus_size,
	output poly_size_t      crc_poly_size,
	output rev_in_t         rev_in_type,
	output logic            rev_out_type,
	output logic            crc_init_en,
	output logic            crc_idr_en,
	output logic            crc_poly_en,
	output logic            buffer_write_en,
	output logic            reset_chain
);

	// Address phase captured for the data phase
	reg_addr_t haddr_pp;
	bus_size_t hsize_pp;
	logic      hwrite_pp;
	logic      active_pp;

	// CR bits 4..0 hold rev_out, rev_in[1:0], poly_size[1:0]
	logic [4:0] cr_q;

	logic sample_bus;
	logic write_en;
	logic read_en;
	logic cr_en;
	logic dr_read;

	//////////////////////////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////////////////////////

	// New address phase accepted when every slave is ready
	assign sample_bus = HREADY && HREADYOUT;

	// Only selected NONSEQ beats become active data phases
	// SEQ and BUSY are dropped here
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			active_pp <= 1'b0;
		else if (sample_bus)
			active_pp <= HSElx && (HTRANS == HTRANS_NONSEQ);
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decode and write enables
	//////////////////////////////////////////////////////////////////////

	assign write_en = active_pp && hwrite_pp;
	assign read_en  = active_pp && !hwrite_pp;

	// Enables stay high for the whole data phase, wait states included
	assign buffer_write_en = write_en && (haddr_pp == REG_DR);
	assign crc_idr_en      = write_en && (haddr_pp == REG_IDR);
	assign cr_en           = write_en && (haddr_pp == REG_CR);
	assign crc_init_en     = write_en && (haddr_pp == REG_INIT);
	assign crc_poly_en     = write_en && (haddr_pp == REG_POL);
	assign dr_read         = read_en && (haddr_pp == REG_DR);

	// Write data arrives in the data phase, no extra flop
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Three stall sources, everything else completes in one cycle
	assign HREADYOUT = !((buffer_write_en && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (crc_init_en && reset_pending));

	assign HRESP = RESP_OKAY;

	//////////////////////////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= CR_RESET;
		else if (cr_en)
			cr_q <= HWDATA[7:3];
	end

	// Bit 0 is a self clearing restart request
	assign reset_chain   = cr_en && HWDATA[0];
	assign crc_poly_size = cr_q[1:0];
	assign rev_in_type   = cr_q[3:2];
	assign rev_out_type  = cr_q[4];

	// Read mux, valid during the data phase
	always_comb
	begin
		case (haddr_pp)
			REG_DR:   HRDATA = crc_out;
			REG_IDR:  HRDATA = {24'h0, crc_idr_out};
			REG_CR:   HRDATA = {24'h0, cr_q, 3'b000};
			REG_INIT: HRDATA = crc_init_out;
			REG_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== crc_input_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_input_buffer
	import crc_bus_pkg::*, crc_calc_pkg::*;
#(
	parameter int BUF_DEPTH = 2
)
(
	input  wire             HCLK,
	input  wire             HRESETn,
	input  wire             buffer_write_en,
	input  wire bus_word_t  bus_wr,
	input  wire bus_size_t  bus_size,
	input  wire             in_ready,
	output logic            buffer_full,
	output logic            buf_empty,
	output logic            in_valid,
	output bus_word_t       in_data,
	output bus_size_t       in_size
);

	// At least one pointer bit, even for a single entry
	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUF_DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUF_DEPTH);

	// Each word keeps the HSIZE of its own beat
	bus_word_t data_mem [BUF_DEPTH];
	bus_size_t size_mem [BUF_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Held write beat is taken once there is room
	assign push = buffer_write_en && !buffer_full;
	assign pop  = in_valid && in_ready;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (push)
		begin
			data_mem[wr_ptr] <= bus_wr;
			size_mem[wr_ptr] <= bus_size;
		end
	end

	assign buffer_full = (count == FULL_CNT);
	assign buf_empty   = (count == '0);
	assign in_valid    = !buf_empty;
	assign in_data     = data_mem[rd_ptr];
	assign in_size     = size_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== crc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_engine
	import crc_bus_pkg::*, crc_calc_pkg::*;
(
	input  wire              HCLK,
	input  wire              HRESETn,
	input  wire              in_valid,
	input  wire bus_word_t   in_data,
	input  wire bus_size_t   in_size,
	input  wire              buf_empty,
	input  wire bus_word_t   bus_wr,
	input  wire              crc_init_en,
	input  wire              crc_idr_en,
	input  wire              crc_poly_en,
	input  wire              reset_chain,
	input  wire poly_size_t  crc_poly_size,
	input  wire rev_in_t     rev_in_type,
	input  wire              rev_out_type,
	output logic             in_ready,
	output crc_word_t        crc_out,
	output crc_word_t        crc_init_out,
	output crc_word_t        crc_poly_out,
	output idr_t             crc_idr_out,
	output logic             reset_pending,
	output logic             read_wait
);

	// Left shift that puts the CRC msb at bit 31
	function automatic logic [4:0] width_shift(input poly_size_t size);
		case (size)
			POLY_32: return 5'd0;
			POLY_16: return 5'd16;
			POLY_8:  return 5'd24;
			default: return 5'd25;
		endcase
	endfunction

	// Bit reversal inside groups of 8, 16 or 32 bits
	function automatic crc_word_t rev_bits(input crc_word_t w, input rev_in_t mode);
		crc_word_t r;
		int        g;
		case (mode)
			REV_BYTE: g = 8;
			REV_HALF: g = 16;
			REV_WORD: g = 32;
			default:  g = 1;
		endcase
		for (int i = 0; i < 32; i++)
			r[i] = w[(i / g) * g + g - 1 - (i % g)];
		return r;
	endfunction

	// One byte, MSB first, non-reflected
	// Working aligned to bit 31 lets one loop serve all widths
	function automatic crc_word_t crc_byte(input crc_word_t crc, input logic [7:0] data,
		input crc_word_t poly, input poly_size_t size);
		logic [4:0] sh;
		crc_word_t  acc;
		crc_word_t  pa;
		sh  = width_shift(size);
		acc = crc << sh;
		pa  = poly << sh;
		for (int b = 7; b >= 0; b--)
		begin
			if (acc[31] ^ data[b])
				acc = (acc << 1) ^ pa;
			else
				acc = acc << 1;
		end
		return acc >> sh;
	endfunction

	engine_state_t state_q;
	crc_word_t     crc_q;
	crc_word_t     poly_q;
	crc_word_t     init_q;
	idr_t          idr_q;
	logic          pending_q;
	logic [1:0]    byte_cnt_q;

	// Word in flight
	bus_word_t word_q;
	bus_size_t size_q;
	bus_word_t shift_q;
	bus_word_t rev_word;
	bus_word_t aligned;
	logic [1:0] last_byte;
	crc_word_t  crc_masked;

	//////////////////////////////////////////////////////////////////////
	// Programmable registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_q <= POLY_RESET;
			init_q <= INIT_RESET;
			idr_q  <= '0;
		end
		else
		begin
			if (crc_poly_en)
				poly_q <= bus_wr;
			// The bus holds this beat until the restart has used the old value
			if (crc_init_en && !pending_q)
				init_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Byte serial FSM
	//////////////////////////////////////////////////////////////////////

	// A pending restart blocks new words so that they start from INIT
	assign in_ready = (state_q == ENG_IDLE) && !pending_q;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q    <= ENG_IDLE;
			crc_q      <= INIT_RESET;
			pending_q  <= 1'b0;
			byte_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				ENG_IDLE:
				begin
					if (pending_q)
						crc_q <= init_q;
					else if (in_valid)
						state_q <= ENG_LOAD;
				end
				ENG_LOAD:
				begin
					byte_cnt_q <= last_byte;
					state_q    <= ENG_SHIFT;
				end
				default:
				begin
					crc_q <= crc_byte(crc_q, shift_q[31:24], poly_q, crc_poly_size);
					if (byte_cnt_q == 2'd0)
						state_q <= ENG_IDLE;
					else
						byte_cnt_q <= byte_cnt_q - 1'b1;
				end
			endcase
			// Restart applies on the first idle cycle
			if (reset_chain)
				pending_q <= 1'b1;
			else if (state_q == ENG_IDLE)
				pending_q <= 1'b0;
		end
	end

	// Input reversal then keep the low 1, 2 or 4 bytes at the top
	always_comb
	begin
		rev_word = rev_bits(word_q, rev_in_type);
		case (size_q)
			SIZE_BYTE:
			begin
				aligned   = {rev_word[7:0], 24'h0};
				last_byte = 2'd0;
			end
			SIZE_HALF:
			begin
				aligned   = {rev_word[15:0], 16'h0};
				last_byte = 2'd1;
			end
			default:
			begin
				aligned   = rev_word;
				last_byte = 2'd3;
			end
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (in_valid && in_ready)
		begin
			word_q <= in_data;
			size_q <= in_size;
		end
		if (state_q == ENG_LOAD)
			shift_q <= aligned;
		else if (state_q == ENG_SHIFT)
			shift_q <= shift_q << 8;
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////

	assign crc_masked = crc_q & (32'hFFFF_FFFF >> width_shift(crc_poly_size));
	assign crc_out    = rev_out_type ? rev_bits(crc_masked, REV_WORD) : crc_masked;

	assign crc_init_out  = init_q;
	assign crc_poly_out  = poly_q;
	assign crc_idr_out   = idr_q;
	assign reset_pending = pending_q;

	// A DR read waits for all queued work and any pending restart
	assign read_wait = (state_q != ENG_IDLE) || !buf_empty || pending_q;

endmodule

`default_nettype wire

// ==== crc_ahb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_top
	import crc_bus_pkg::*, crc_calc_pkg::*;
#(
	parameter int BUF_DEPTH = 2
)
(
	input  wire             HCLK,
	input  wire             HRESETn,
	input  wire             HSElx,
	input  wire bus_word_t  HADDR,
	input  wire [1:0]       HTRANS,
	input  wire [2:0]       HSIZE,
	input  wire             HWRITE,
	input  wire bus_word_t  HWDATA,
	input  wire             HREADY,
	output bus_word_t       HRDATA,
	output logic            HREADYOUT,
	output logic            HRESP
);

	// Slave to buffer and engine
	bus_word_t  bus_wr;
	bus_size_t  bus_size;
	poly_size_t crc_poly_size;
	rev_in_t    rev_in_type;
	logic       rev_out_type;
	logic       crc_init_en;
	logic       crc_idr_en;
	logic       crc_poly_en;
	logic       buffer_write_en;
	logic       reset_chain;

	// Engine and buffer back to the slave
	crc_word_t  crc_out;
	crc_word_t  crc_init_out;
	crc_word_t  crc_poly_out;
	idr_t       crc_idr_out;
	logic       buffer_full;
	logic       reset_pending;
	logic       read_wait;

	// Buffer to engine handshake
	logic       buf_empty;
	logic       in_valid;
	logic       in_ready;
	bus_word_t  in_data;
	bus_size_t  in_size;

	host_interface u_host_interface (.*);

	crc_input_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_crc_input_buffer (.*);

	crc_engine u_crc_engine (.*);

endmodule

`default_nettype wire

// ==== tb_crc_ahb_model.svh ====
// Register model updated as each write beat completes
crc_word_t  model_crc  = 32'hFFFF_FFFF;
crc_word_t  model_init = 32'hFFFF_FFFF;
crc_word_t  model_poly = 32'h04C1_1DB7;
idr_t       model_idr  = 8'h00;
logic [4:0] model_cr   = 5'h00;

// CRC width in bits for each size code
function automatic int poly_width(input poly_size_t ps);
	case (ps)
		2'b00:   return 32;
		2'b01:   return 16;
		2'b10:   return 8;
		default: return 7;
	endcase
endfunction

function automatic crc_word_t width_mask(input poly_size_t ps);
	return (poly_width(ps) == 32) ? 32'hFFFF_FFFF : (32'h1 << poly_width(ps)) - 1;
endfunction

// Mirror the bits inside each group of 8, 16 or 32
function automatic bus_word_t reverse_groups(input bus_word_t w, input rev_in_t ri);
	bus_word_t r;
	int        g;
	g = (ri == 2'b01) ? 8 : (ri == 2'b10) ? 16 : (ri == 2'b11) ? 32 : 0;
	if (g == 0)
		return w;
	for (int base = 0; base < 32; base += g)
		for (int j = 0; j < g; j++)
			r[base + j] = w[base + g - 1 - j];
	return r;
endfunction

// Step the model CRC through one data word
// Kept bytes go high byte first and each byte MSB first
function automatic crc_word_t crc_model(input crc_word_t crc, input bus_word_t data,
	input bus_size_t size, input poly_size_t ps, input crc_word_t poly, input rev_in_t ri);
	bus_word_t  w;
	crc_word_t  mask;
	int         width;
	int         nbytes;
	logic [7:0] b;
	logic       fb;
	width  = poly_width(ps);
	mask   = width_mask(ps);
	w      = reverse_groups(data, ri);
	nbytes = (size == 2'b00) ? 1 : (size == 2'b01) ? 2 : 4;
	for (int k = nbytes - 1; k >= 0; k--)
	begin
		b = w[8*k +: 8];
		for (int i = 7; i >= 0; i--)
		begin
			fb  = crc[width-1] ^ b[i];
			crc = (crc << 1) & mask;
			if (fb)
				crc = crc ^ (poly & mask);
		end
	end
	return crc;
endfunction

// DR readback masked to the width and optionally mirrored
function automatic bus_word_t crc_readback(input crc_word_t crc, input logic [4:0] cr);
	bus_word_t masked;
	masked = crc & width_mask(cr[1:0]);
	return cr[4] ? reverse_groups(masked, 2'b11) : masked;
endfunction

// Expected readback of a register
function automatic bus_word_t model_read(input reg_addr_t idx);
	case (idx)
		REG_DR:   return crc_readback(model_crc, model_cr);
		REG_IDR:  return {24'h0, model_idr};
		REG_CR:   return {24'h0, model_cr, 3'b000};
		REG_INIT: return model_init;
		REG_POL:  return model_poly;
		default:  return 32'h0;
	endcase
endfunction

task automatic model_write(input reg_addr_t idx, input bus_size_t size, input bus_word_t data);
	case (idx)
		REG_DR:   model_crc = crc_model(model_crc, data, size, model_cr[1:0], model_poly,
			model_cr[3:2]);
		REG_IDR:  model_idr = data[7:0];
		REG_CR:
		begin
			model_cr = data[7:3];
			// Restart bit reloads the chain from INIT
			if (data[0])
				model_crc = model_init;
		end
		REG_INIT: model_init = data;
		REG_POL:  model_poly = data;
		default:  ;
	endcase
endtask

// Compare tasks for each kind of result
task automatic check_word(input bus_word_t got, input bus_word_t exp, input string name);
	if (got !== exp)
	begin
		$display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		abort_run("Read data mismatch");
	end
endtask

task automatic check_idr(input idr_t got, input idr_t exp, input string name);
	if (got !== exp)
	begin
		$display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		abort_run("Scratch register mismatch");
	end
endtask

task automatic check_resp(input logic got, input string name);
	if (got !== 1'b0)
	begin
		$display("Fail time=%0t signal=%s got=%b expected=%b", $time, name, got, 1'b0);
		abort_run("Slave response was not OKAY");
	end
endtask

// ==== tb_crc_ahb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_crc_ahb
	import crc_bus_pkg::*, crc_calc_pkg::*;
();

	localparam int CLK_PERIOD  = 20;
	localparam int N_WORDS     = 12;
	// Beats issued by the whole sequence, rounded up
	localparam int TEST_BEATS  = 40 + N_WORDS + 4 * 9 + 8 * 5;
	// Two bus cycles plus a full buffer drain per beat
	localparam int STALL_BOUND = 32;

	integer seed = 32'h369d;

	logic      HCLK = 1'b0;
	logic      HRESETn;
	logic      HSElx;
	bus_word_t HADDR;
	logic [1:0] HTRANS;
	logic [2:0] HSIZE;
	logic      HWRITE;
	bus_word_t HWDATA;
	wire       HREADY;
	bus_word_t HRDATA;
	logic      HREADYOUT;
	logic      HRESP;

	// Completed reads waiting for the checker
	reg_addr_t read_idx_q[$];
	bus_word_t read_got_q[$];
	bus_word_t read_exp_q[$];

	// Single slave on the bus
	assign HREADY = HREADYOUT;

	always #(CLK_PERIOD / 2) HCLK = ~HCLK;

	crc_ahb_top #(
		.BUF_DEPTH (2)
	) u_crc_ahb_top (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	`include "tb_crc_ahb_model.svh"

	//////////////////////////////////////////////////////////////////////
	// AHB bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic drive_address(input logic wr, input reg_addr_t idx, input bus_size_t size);
		HSElx  = 1'b1;
		HTRANS = HTRANS_NONSEQ;
		HADDR  = {27'h0, idx, 2'b00};
		HSIZE  = {1'b0, size};
		HWRITE = wr;
	endtask

	task automatic drive_idle();
		HSElx  = 1'b0;
		HTRANS = HTRANS_IDLE;
	endtask

	// Edge where the current phase ends
	task automatic wait_ready();
		@(posedge HCLK);
		while (!HREADYOUT)
			@(posedge HCLK);
	endtask

	task automatic bus_transfer(input logic wr, input reg_addr_t idx, input bus_size_t size,
		input bus_word_t wdata, output bus_word_t rdata);
		@(negedge HCLK);
		drive_address(wr, idx, size);
		wait_ready();
		@(negedge HCLK);
		drive_idle();
		HWDATA = wdata;
		wait_ready();
		check_resp(HRESP, "HRESP");
		rdata = HRDATA;
	endtask

	task automatic write_reg(input reg_addr_t idx, input bus_size_t size, input bus_word_t data);
		bus_word_t unused;
		bus_transfer(1'b1, idx, size, data, unused);
		model_write(idx, size, data);
	endtask

	task automatic read_reg(input reg_addr_t idx);
		bus_word_t exp;
		bus_word_t got;
		exp = model_read(idx);
		bus_transfer(1'b0, idx, SIZE_WORD, 32'h0, got);
		read_idx_q.push_back(idx);
		read_got_q.push_back(got);
		read_exp_q.push_back(exp);
	endtask

	// Pipelined DR word writes, next address overlaps the data phase
	task automatic write_dr_burst(input int count);
		bus_word_t words[$];
		for (int i = 0; i <= count; i++)
		begin
			@(negedge HCLK);
			if (i > 0)
				HWDATA = words[i-1];
			if (i < count)
			begin
				words.push_back($random(seed));
				drive_address(1'b1, REG_DR, SIZE_WORD);
			end
			else
				drive_idle();
			wait_ready();
			if (i > 0)
			begin
				check_resp(HRESP, "HRESP");
				model_write(REG_DR, SIZE_WORD, words[i-1]);
			end
		end
	endtask

	function automatic bus_word_t cr_value(input poly_size_t ps, input rev_in_t ri,
		input logic ro, input logic restart);
		return {24'h0, ro, ri, ps, 2'b00, restart};
	endfunction

	function automatic string reg_name(input reg_addr_t idx);
		case (idx)
			REG_DR:   return "HRDATA (DR)";
			REG_CR:   return "HRDATA (CR)";
			REG_INIT: return "HRDATA (INIT)";
			default:  return "HRDATA (POL)";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checker and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		bus_word_t got;
		bus_word_t exp;
		reg_addr_t idx;
		forever
		begin
			wait (read_idx_q.size() != 0);
			idx = read_idx_q[0];
			got = read_got_q[0];
			exp = read_exp_q[0];
			if (idx == REG_IDR)
			begin
				check_idr(idr_t'(got[7:0]), idr_t'(exp[7:0]), "HRDATA (IDR)");
				check_word(got & 32'hFFFF_FF00, 32'h0, "HRDATA (IDR upper bits)");
			end
			else
				check_word(got, exp, reg_name(idx));
			// Popped only after the compare so the end of run sees it done
			read_idx_q.pop_front();
			read_got_q.pop_front();
			read_exp_q.pop_front();
		end
	end

	initial
	begin
		#((8 + TEST_BEATS * STALL_BOUND) * CLK_PERIOD);
		abort_run("Timeout, the bus stalled and the test sequence never finished");
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		HRESETn = 1'b0;
		HSElx   = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = HTRANS_IDLE;
		HSIZE   = 3'b010;
		HWRITE  = 1'b0;
		HWDATA  = 32'h0;
		repeat (8) @(negedge HCLK);
		HRESETn = 1'b1;

		// Reset values
		read_reg(REG_POL);
		read_reg(REG_INIT);
		read_reg(REG_CR);
		read_reg(REG_IDR);
		read_reg(REG_DR);

		// Write and readback, restart bit left clear
		write_reg(REG_IDR, SIZE_WORD, $random(seed));
		write_reg(REG_POL, SIZE_WORD, $random(seed));
		write_reg(REG_INIT, SIZE_WORD, $random(seed));
		write_reg(REG_CR, SIZE_WORD, 32'hFFFF_FF5A);
		read_reg(REG_IDR);
		read_reg(REG_POL);
		read_reg(REG_INIT);
		read_reg(REG_CR);

		// Default CRC-32, more words than the buffer holds
		write_reg(REG_POL, SIZE_WORD, 32'h04C1_1DB7);
		write_reg(REG_INIT, SIZE_WORD, 32'hFFFF_FFFF);
		write_reg(REG_CR, SIZE_WORD, cr_value(POLY_32, REV_NONE, 1'b0, 1'b1));
		write_dr_burst(N_WORDS);
		read_reg(REG_DR);

		// Every width with byte, halfword and word beats
		for (int p = 0; p < 4; p++)
		begin
			write_reg(REG_POL, SIZE_WORD, (p == 0) ? 32'h04C1_1DB7 : (p == 1) ? 32'h1021 :
				(p == 2) ? 32'h07 : 32'h09);
			write_reg(REG_CR, SIZE_WORD, cr_value(poly_size_t'(p), REV_NONE, 1'b0, 1'b1));
			for (int k = 0; k < 6; k++)
				write_reg(REG_DR, bus_size_t'(k % 3), $random(seed));
			read_reg(REG_DR);
		end

		// Input reversal types, output reversal off then on
		write_reg(REG_POL, SIZE_WORD, 32'h04C1_1DB7);
		for (int r = 0; r < 8; r++)
		begin
			write_reg(REG_CR, SIZE_WORD, cr_value(POLY_32, rev_in_t'(r % 4), r >= 4, 1'b1));
			for (int k = 0; k < 3; k++)
				write_reg(REG_DR, bus_size_t'(k), $random(seed));
			read_reg(REG_DR);
		end

		// Restart from a new INIT once the chain has moved on
		write_reg(REG_DR, SIZE_WORD, $random(seed));
		read_reg(REG_DR);
		write_reg(REG_INIT, SIZE_WORD, $random(seed));
		write_reg(REG_CR, SIZE_WORD, cr_value(POLY_16, REV_BYTE, 1'b1, 1'b1));
		write_reg(REG_DR, SIZE_HALF, $random(seed));
		write_reg(REG_DR, SIZE_WORD, $random(seed));
		read_reg(REG_DR);
		read_reg(REG_INIT);

		wait (read_idx_q.size() == 0);
		@(negedge HCLK);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
crc_bus_pkg.sv
crc_calc_pkg.sv
host_interface.sv
crc_input_buffer.sv
crc_engine.sv
crc_ahb_top.sv
tb_crc_ahb.sv
